// File: logic/acc_settings.svh
`ifndef ACC_SETTINGS_SVH
`define ACC_SETTINGS_SVH

// width of the step counter inside the sequencer
`define ACC_CNT_W 5

// number of the last step in a run, so a run has 26 steps
`define ACC_CNT_LAST 25

// width of one host sample and of one weight
`define ACC_SAMPLE_W 8

// width of each running sum
// wraps silently when exceeded
`define ACC_SUM_W 20

// number of accumulators in the bank, one per enable bit
`define ACC_LANES 4

`endif

// File: logic/acc_pkg.sv
`include "acc_settings.svh"

package acc_pkg;

    // sequencer states
    // IDLE waits for start, RUN walks the steps, FLUSH drains the pipeline
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        FLUSH = 2'd2
    } seq_state_e;

    // one host sample or weight, two's complement
    typedef logic signed [`ACC_SAMPLE_W-1:0] sample_t;

    // full-precision product of sample and weight
    typedef logic signed [2*`ACC_SAMPLE_W-1:0] product_t;

    // running sum held by each accumulator
    typedef logic signed [`ACC_SUM_W-1:0] sum_t;

endpackage

// File: logic/acc_sequencer.sv
`timescale 1ns/1ps
`include "acc_settings.svh"

module acc_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    output logic                  busy,
    output logic                  done,
    output logic                  clear,
    output logic                  step_valid,
    output logic [`ACC_CNT_W-1:0] step_cnt
);
    import acc_pkg::*;

    seq_state_e state;

    // second flush cycle marker
    logic       drain;

    // one FSM drives the counter and the strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            step_cnt <= '0;
            drain    <= 1'b0;
            clear    <= 1'b0;
            done     <= 1'b0;
        end else begin
            // strobes are single-cycle unless set below
            clear <= 1'b0;
            done  <= 1'b0;
            case (state)
                IDLE: begin
                    // start only counts here, so a start while busy is dropped
                    if (start) begin
                        state    <= RUN;
                        step_cnt <= '0;
                        clear    <= 1'b1;
                    end
                end
                RUN: begin
                    if (step_cnt == `ACC_CNT_W'(`ACC_CNT_LAST)) begin
                        // last step has been issued to lane and decoder
                        state <= FLUSH;
                        drain <= 1'b0;
                    end else begin
                        step_cnt <= step_cnt + 1'b1;
                    end
                end
                FLUSH: begin
                    // first cycle, the last product sits in the stage registers
                    // second cycle, the bank has it and done is out
                    if (!drain) begin
                        drain <= 1'b1;
                        done  <= 1'b1;
                    end else begin
                        drain <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // a step is live for every cycle of RUN
    assign step_valid = (state == RUN);

    // busy stays up through the done cycle and drops after it
    assign busy = (state != IDLE);

endmodule

// File: logic/acc_en_decoder.sv
`timescale 1ns/1ps
`include "acc_settings.svh"

module acc_en_decoder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  step_valid,
    input  logic [`ACC_CNT_W-1:0] step_cnt,
    output logic [`ACC_LANES-1:0] acc_en
);

    // complemented count literals
    logic [`ACC_CNT_W-1:0] cnt_n;

    // product terms, one vector per enable bit
    logic [4:0]            prod3;
    logic [3:0]            prod2;
    logic [6:0]            prod1;
    logic [4:0]            prod0;

    // unregistered enable from the sum of products
    logic [`ACC_LANES-1:0] en_sop;

    assign cnt_n = ~step_cnt;

    // acc3 enable terms
    // patterns are cnt[4:0], with - as don't care
    assign prod3[0] = cnt_n[4] & step_cnt[2] & cnt_n[1] & step_cnt[0];     // 0-101
    assign prod3[1] = cnt_n[4] & cnt_n[3] & step_cnt[2] & step_cnt[1];     // 0011-
    assign prod3[2] = cnt_n[4] & step_cnt[3] & cnt_n[2] & step_cnt[0];     // 010-1
    assign prod3[3] = step_cnt[4] & cnt_n[3] & cnt_n[1] & cnt_n[0];        // 10-00
    assign prod3[4] = step_cnt[4] & cnt_n[3] & cnt_n[2] & cnt_n[0];        // 100-0

    // acc2 enable terms
    assign prod2[0] = cnt_n[4] & cnt_n[3] & step_cnt[2] & step_cnt[1];     // 0011-
    assign prod2[1] = step_cnt[4] & cnt_n[3] & cnt_n[1] & step_cnt[0];     // 10-01
    assign prod2[2] = cnt_n[4] & step_cnt[3] & cnt_n[0];                   // 01--0
    assign prod2[3] = step_cnt[4] & cnt_n[3] & cnt_n[2] & step_cnt[0];     // 100-1

    // acc1 enable terms
    // the three full minterms pick single steps 10, 9 and 12
    assign prod1[0] = cnt_n[4] & step_cnt[3] & cnt_n[2] & step_cnt[1] & cnt_n[0];
    assign prod1[1] = cnt_n[4] & step_cnt[3] & cnt_n[2] & cnt_n[1] & step_cnt[0];
    assign prod1[2] = cnt_n[4] & step_cnt[3] & step_cnt[2] & cnt_n[1] & cnt_n[0];
    assign prod1[3] = step_cnt[4] & cnt_n[3] & step_cnt[2] & step_cnt[1];  // 1011-
    assign prod1[4] = step_cnt[4] & step_cnt[3] & cnt_n[2] & cnt_n[1] & cnt_n[0];
    assign prod1[5] = step_cnt[4] & cnt_n[3] & cnt_n[2] & cnt_n[1];        // 1000-
    assign prod1[6] = step_cnt[4] & cnt_n[3] & cnt_n[2] & step_cnt[0];     // 100-1

    // acc0 enable terms
    assign prod0[0] = cnt_n[4] & step_cnt[3] & step_cnt[2] & cnt_n[1] & cnt_n[0];
    assign prod0[1] = cnt_n[4] & step_cnt[3] & step_cnt[1] & cnt_n[0];     // 01-10
    assign prod0[2] = step_cnt[4] & step_cnt[3] & cnt_n[2] & cnt_n[1] & cnt_n[0];
    assign prod0[3] = step_cnt[4] & cnt_n[2] & cnt_n[1] & step_cnt[0];     // 1-001
    assign prod0[4] = step_cnt[4] & cnt_n[3] & step_cnt[0];                // 10--1

    // OR plane
    // counts 26 to 31 hit no term, so no extra range check
    assign en_sop[3] = |prod3;
    assign en_sop[2] = |prod2;
    assign en_sop[1] = |prod1;
    assign en_sop[0] = |prod0;

    // one register stage, aligned with the product lane
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_en <= '0;
        end else if (step_valid) begin
            acc_en <= en_sop;
        end else begin
            // no live step, so no accumulator may move
            acc_en <= '0;
        end
    end

endmodule

// File: logic/product_lane.sv
`timescale 1ns/1ps
`include "acc_settings.svh"

module product_lane (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              step_valid,
    input  acc_pkg::sample_t  sample,
    input  acc_pkg::sample_t  weight,
    output acc_pkg::product_t prod,
    output logic              prod_valid
);
    import acc_pkg::*;

    // full-width signed product, both operands are signed types
    product_t prod_d;

    assign prod_d = sample * weight;

    // product register
    // only loads on a live step, holds otherwise
    always_ff @(posedge clk) begin
        if (step_valid) begin
            prod <= prod_d;
        end
    end

    // valid travels with the product through the same stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= step_valid;
        end
    end

endmodule

// File: logic/acc_bank.sv
`timescale 1ns/1ps
`include "acc_settings.svh"

module acc_bank (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clear,
    input  logic                  prod_valid,
    input  logic [`ACC_LANES-1:0] acc_en,
    input  acc_pkg::product_t     prod,
    output acc_pkg::sum_t         acc0,
    output acc_pkg::sum_t         acc1,
    output acc_pkg::sum_t         acc2,
    output acc_pkg::sum_t         acc3
);
    import acc_pkg::*;

    // running sums, index matches the acc_en bit
    sum_t acc_q [`ACC_LANES];

    // product widened to the sum width
    sum_t prod_ext;

    // sign extension of the 16-bit product
    assign prod_ext = {{(`ACC_SUM_W - 2*`ACC_SAMPLE_W){prod[2*`ACC_SAMPLE_W-1]}}, prod};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ACC_LANES; i++) begin
                acc_q[i] <= '0;
            end
        end else if (clear) begin
            // start of a new run
            // clear lands one edge before the first product arrives
            for (int i = 0; i < `ACC_LANES; i++) begin
                acc_q[i] <= '0;
            end
        end else if (prod_valid) begin
            // each lane adds only when its decoder bit is set
            for (int i = 0; i < `ACC_LANES; i++) begin
                if (acc_en[i]) begin
                    // plain wrap at ACC_SUM_W bits
                    acc_q[i] <= acc_q[i] + prod_ext;
                end
            end
        end
    end

    // sums stay visible between runs
    assign acc0 = acc_q[0];
    assign acc1 = acc_q[1];
    assign acc2 = acc_q[2];
    assign acc3 = acc_q[3];

endmodule

// File: logic/acc_top.sv
`timescale 1ns/1ps
`include "acc_settings.svh"

module acc_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  acc_pkg::sample_t sample,
    input  acc_pkg::sample_t weight,
    output logic             busy,
    output logic             done,
    output acc_pkg::sum_t    acc0,
    output acc_pkg::sum_t    acc1,
    output acc_pkg::sum_t    acc2,
    output acc_pkg::sum_t    acc3
);
    import acc_pkg::*;

    // sequencer to lane and decoder
    logic                  step_valid;
    logic [`ACC_CNT_W-1:0] step_cnt;

    // sequencer to bank
    logic                  clear;

    // stage outputs into the bank
    product_t              prod;
    logic                  prod_valid;
    logic [`ACC_LANES-1:0] acc_en;

    acc_sequencer acc_sequencer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .clear      (clear),
        .step_valid (step_valid),
        .step_cnt   (step_cnt)
    );

    // decoder and lane sit side by side, one stage each
    acc_en_decoder acc_en_decoder_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .step_valid (step_valid),
        .step_cnt   (step_cnt),
        .acc_en     (acc_en)
    );

    product_lane product_lane_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .step_valid (step_valid),
        .sample     (sample),
        .weight     (weight),
        .prod       (prod),
        .prod_valid (prod_valid)
    );

    acc_bank acc_bank_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .prod_valid (prod_valid),
        .acc_en     (acc_en),
        .prod       (prod),
        .acc0       (acc0),
        .acc1       (acc1),
        .acc2       (acc2),
        .acc3       (acc3)
    );

endmodule

// File: verif/acc_clk_gen.sv
`timescale 1ns/1ps

module acc_clk_gen (
    output logic clk
);

    // 4 ns period, low for the first half
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule

// File: verif/acc_asserts.sv
`timescale 1ns/1ps
`include "acc_settings.svh"

module acc_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  start,
    input logic                  busy,
    input logic                  done,
    input logic                  prod_valid,
    input logic [`ACC_LANES-1:0] acc_en,
    input acc_pkg::sum_t         acc0,
    input acc_pkg::sum_t         acc1,
    input acc_pkg::sum_t         acc2,
    input acc_pkg::sum_t         acc3
);
    import acc_pkg::*;

    // tracks an accepted run, run_cyc is k in the cycle after edge k
    logic       in_run;
    logic [5:0] run_cyc;

    // one sticky flag per property, read by the testbench
    logic fail_reset  = 1'b0;
    logic fail_due    = 1'b0;
    logic fail_timing = 1'b0;
    logic fail_pulse  = 1'b0;
    logic fail_busy   = 1'b0;
    logic fail_drop   = 1'b0;
    logic fail_gate   = 1'b0;
    logic any_fail;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_run  <= 1'b0;
            run_cyc <= '0;
        end else if (start && !busy) begin
            // start only counts while idle
            in_run  <= 1'b1;
            run_cyc <= '0;
        end else if (done) begin
            in_run <= 1'b0;
        end else if (in_run) begin
            run_cyc <= run_cyc + 6'd1;
        end
    end

    // nothing moves straight out of reset
    a_reset_clean: assert property (@(posedge clk)
        $rose(rst_n) |-> (!busy && !done && acc_en == '0 &&
                          acc0 == '0 && acc1 == '0 && acc2 == '0 && acc3 == '0))
        else begin
            fail_reset = 1'b1;
            $error("strobes, enables or sums not clear after reset");
        end

    // done is due 27 cycles after the start edge
    a_done_due: assert property (@(posedge clk) disable iff (!rst_n)
        (in_run && run_cyc == 6'd27) |-> done)
        else begin
            fail_due = 1'b1;
            $error("done missing 27 cycles after start");
        end

    // and never at any other time
    a_done_timing: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (in_run && run_cyc == 6'd27))
        else begin
            fail_timing = 1'b1;
            $error("done outside its slot");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin
            fail_pulse = 1'b1;
            $error("done held longer than one cycle");
        end

    a_busy_held: assert property (@(posedge clk) disable iff (!rst_n)
        in_run |-> busy)
        else begin
            fail_busy = 1'b1;
            $error("busy dropped during a run");
        end

    a_busy_drop: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !busy)
        else begin
            fail_drop = 1'b1;
            $error("busy still high after done");
        end

    // decoder output is gated by the lane valid
    a_en_gated: assert property (@(posedge clk) disable iff (!rst_n)
        !prod_valid |-> (acc_en == '0))
        else begin
            fail_gate = 1'b1;
            $error("acc_en set without prod_valid");
        end

    assign any_fail = fail_reset | fail_due | fail_timing | fail_pulse |
                      fail_busy | fail_drop | fail_gate;

endmodule

// File: verif/acc_tb.sv
`timescale 1ns/1ps
`include "acc_settings.svh"

module acc_tb;
    import acc_pkg::*;

    // six runs of about 30 cycles each, plus reset and slack
    localparam int RUN_CNT     = 6;
    localparam int TIMEOUT_CYC = RUN_CNT * 30 + 8 + 40;
    localparam int STEPS       = `ACC_CNT_LAST + 1;

    logic    clk;
    logic    rst_n;
    logic    start;
    sample_t sample;
    sample_t weight;
    logic    busy;
    logic    done;
    sum_t    acc0;
    sum_t    acc1;
    sum_t    acc2;
    sum_t    acc3;

    int      cyc_cnt = 0;
    logic    sva_failed;

    acc_clk_gen acc_clk_gen_inst (
        .clk (clk)
    );

    acc_top acc_top_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .sample (sample),
        .weight (weight),
        .busy   (busy),
        .done   (done),
        .acc0   (acc0),
        .acc1   (acc1),
        .acc2   (acc2),
        .acc3   (acc3)
    );

    // timing properties ride inside the DUT, on its internal wires
    bind acc_top acc_asserts acc_asserts_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .prod_valid (prod_valid),
        .acc_en     (acc_en),
        .acc0       (acc0),
        .acc1       (acc1),
        .acc2       (acc2),
        .acc3       (acc3)
    );

    assign sva_failed = acc_top_inst.acc_asserts_inst.any_fail;

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // enable table by step, bit i feeds acc i
    function automatic logic [`ACC_LANES-1:0] table_enables(input int step);
        case (step)
            5:       return 4'h8;
            6:       return 4'hC;
            7:       return 4'hC;
            8:       return 4'h4;
            9:       return 4'hA;
            10:      return 4'h7;
            11:      return 4'h8;
            12:      return 4'h7;
            13:      return 4'h8;
            14:      return 4'h5;
            16:      return 4'hA;
            17:      return 4'h7;
            18:      return 4'h8;
            19:      return 4'h7;
            20:      return 4'h8;
            21:      return 4'h5;
            22:      return 4'h2;
            23:      return 4'h3;
            24:      return 4'h3;
            25:      return 4'h1;
            default: return 4'h0;
        endcase
    endfunction

    task automatic check_sum(input string name, input sum_t got, input sum_t exp);
        assert (got === exp) else begin
            $display("mismatch %s got %h exp %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // strobes and enables, narrow values up to the enable width
    task automatic check_flag(input string name, input logic [`ACC_LANES-1:0] got,
                              input logic [`ACC_LANES-1:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s got %h exp %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // one run, entered and left on a falling edge with the DUT idle
    task automatic run_once(input bit all_ones, input bit poke_busy);
        sample_t               smp [STEPS];
        sample_t               wgt [STEPS];
        sum_t                  exp_sum [`ACC_LANES];
        product_t              p;
        logic [31:0]           rnd;
        logic [`ACC_LANES-1:0] en;
        for (int k = 0; k < STEPS; k++) begin
            if (all_ones) begin
                smp[k] = '1;
                wgt[k] = '1;
            end else begin
                rnd    = $urandom;
                smp[k] = sample_t'(rnd);
                wgt[k] = sample_t'(rnd >> 16);
            end
        end
        // model, sums start from zero on every run and wrap at sum_t
        for (int i = 0; i < `ACC_LANES; i++) begin
            exp_sum[i] = '0;
        end
        for (int k = 0; k < STEPS; k++) begin
            p  = smp[k] * wgt[k];
            en = table_enables(k);
            for (int i = 0; i < `ACC_LANES; i++) begin
                if (en[i]) begin
                    exp_sum[i] = exp_sum[i] + sum_t'(p);
                end
            end
        end
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        // start while idle must be taken
        check_flag("busy", busy, 1);
        // step k data sits in the middle of step k's cycle
        for (int k = 0; k < STEPS; k++) begin
            sample = smp[k];
            weight = wgt[k];
            start  = (poke_busy && k == 10);
            @(negedge clk);
        end
        start = 1'b0;
        // junk after the last step must not reach the sums
        rnd    = $urandom;
        sample = sample_t'(rnd);
        weight = sample_t'(rnd >> 8);
        while (!done) begin
            @(negedge clk);
        end
        check_sum("acc0", acc0, exp_sum[0]);
        check_sum("acc1", acc1, exp_sum[1]);
        check_sum("acc2", acc2, exp_sum[2]);
        check_sum("acc3", acc3, exp_sum[3]);
        @(negedge clk);
    endtask

    // hang guard and link to the bound properties
    always @(negedge clk) begin
        cyc_cnt = cyc_cnt + 1;
        if (sva_failed) begin
            $display("a bound timing assertion failed");
            stop_with_failure();
        end else if (cyc_cnt >= TIMEOUT_CYC) begin
            $display("timeout after %0d cycles without reaching the end", cyc_cnt);
            stop_with_failure();
        end
    end

    initial begin
        void'($urandom(46366));
        rst_n  = 1'b0;
        start  = 1'b0;
        sample = '0;
        weight = '0;
        repeat (8) begin
            @(negedge clk);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("busy", busy, '0);
        check_flag("done", done, '0);
        check_flag("acc_en", acc_top_inst.acc_en, '0);
        check_sum("acc0", acc0, '0);
        check_sum("acc1", acc1, '0);
        check_sum("acc2", acc2, '0);
        check_sum("acc3", acc3, '0);
        // four back-to-back random runs
        for (int r = 0; r < 4; r++) begin
            run_once(1'b0, 1'b0);
        end
        // stray start in the middle of a run
        run_once(1'b0, 1'b1);
        // all ones gives small counts, so stale sums would show
        run_once(1'b1, 1'b0);
        repeat (4) begin
            @(negedge clk);
        end
        if (!sva_failed) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

// File: src.f
+incdir+logic
logic/acc_pkg.sv
logic/acc_sequencer.sv
logic/acc_en_decoder.sv
logic/product_lane.sv
logic/acc_bank.sv
logic/acc_top.sv
verif/acc_clk_gen.sv
verif/acc_asserts.sv
verif/acc_tb.sv

// File: Makefile
# Verilator flow for the accumulate engine testbench

VERILATOR  ?= verilator
TOP        ?= acc_tb
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Simulation failed
PASS_MSG   ?= Simulation completed successfully
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing --assert
SIM_ARGS   ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "result: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "result: no pass line"; exit 1; fi
	@echo "result: PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
